//--- common/mem_cfg.svh
// configuration macros for the banked memory subsystem
// bank count, bus widths and id split

`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// number of banks and id bits used to pick one
`define MEM_BANKS 4
`define MEM_BANK_BITS 2

// word address inside one bank
`define MEM_ADDR_WIDTH 8

// data bus and its byte mask
`define MEM_DATA_WIDTH 32
`define MEM_MASK_WIDTH 4

// full request id and the part left once bank bits are stripped
`define MEM_ID_WIDTH 6
`define MEM_BANK_ID_WIDTH 4

`endif

//--- common/mem_pkg.sv
// request and response payload types
// bank index type

`include "mem_cfg.svh"

package mem_pkg;

    typedef logic [`MEM_BANK_BITS-1:0] bank_idx_t;

    // request as seen by the requester
    typedef struct packed {
        logic                        read_enable;
        logic [`MEM_MASK_WIDTH-1:0]  write_enable;
        logic [`MEM_ADDR_WIDTH-1:0]  addr;
        logic [`MEM_DATA_WIDTH-1:0]  data;
        logic [`MEM_ID_WIDTH-1:0]    id;
        logic                        last;
    } mem_req_t;

    // request inside a bank, bank bits removed from id
    typedef struct packed {
        logic                            read_enable;
        logic [`MEM_MASK_WIDTH-1:0]      write_enable;
        logic [`MEM_ADDR_WIDTH-1:0]      addr;
        logic [`MEM_DATA_WIDTH-1:0]      data;
        logic [`MEM_BANK_ID_WIDTH-1:0]   id;
        logic                            last;
    } mem_bank_req_t;

    typedef struct packed {
        logic                        is_write;
        logic [`MEM_DATA_WIDTH-1:0]  data;
        logic [`MEM_ID_WIDTH-1:0]    id;
        logic                        last;
    } mem_resp_t;

    typedef struct packed {
        logic                            is_write;
        logic [`MEM_DATA_WIDTH-1:0]      data;
        logic [`MEM_BANK_ID_WIDTH-1:0]   id;
        logic                            last;
    } mem_bank_resp_t;

endpackage

//--- common/stream_intf.sv
// valid/ready stream interface with a typed payload
// modports for the receiving and the sending side

interface stream_intf #(
    parameter type T = logic
);

    logic valid;
    logic ready;
    T     payload;

    // receiving side
    modport in (
        input  valid,
        input  payload,
        output ready
    );

    // sending side
    modport out (
        output valid,
        output payload,
        input  ready
    );

endinterface

//--- design/stream_reg_slice.sv
// registered two-entry skid buffer for a valid/ready stream
// payload type given by a type parameter

module stream_reg_slice #(
    parameter type T = logic
) (
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  in,
    stream_intf.out out
);

    logic out_valid_q;
    logic skid_valid_q;
    logic in_ready_q;
    T     out_payload_q;
    T     skid_payload_q;
    logic out_load;
    logic in_xfer;

    // ready comes straight from a flop, so no path runs back upstream
    assign in.ready = in_ready_q;
    assign in_xfer  = in.valid && in_ready_q;

    // output stage free or emptying this cycle
    assign out_load = out.ready || !out_valid_q;

    assign out.valid   = out_valid_q;
    assign out.payload = out_payload_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b0;
        end else begin
            // ready whenever the skid entry is empty next cycle
            in_ready_q <= out_load || (!in_xfer && !skid_valid_q);
            if (out_load) begin
                out_valid_q  <= skid_valid_q || in_xfer;
                skid_valid_q <= 1'b0;
            end else if (in_xfer) begin
                // output stalled, park the new beat
                skid_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_payload_q <= skid_valid_q ? skid_payload_q : in.payload;
        end
        if (!out_load && in_xfer) begin
            skid_payload_q <= in.payload;
        end
    end

endmodule

//--- mem_split/mem_split.sv
// request splitter
// picks a bank from the upper id bits and strips them
// one registered slice per bank output

`include "mem_cfg.svh"

module mem_split
    import mem_pkg::*;
(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  req_in,
    stream_intf.out bank_out [`MEM_BANKS]
);

    mem_req_t           req;
    mem_bank_req_t      bank_req;
    bank_idx_t          bank_sel;
    logic [`MEM_BANKS-1:0] slice_ready;

    stream_intf #(.T(mem_bank_req_t)) slice_in [`MEM_BANKS] ();

    assign req = req_in.payload;

    // bank number sits in the top bits of the id
    assign bank_sel = req.id[`MEM_ID_WIDTH-1 -: `MEM_BANK_BITS];

    always_comb begin
        bank_req.read_enable  = req.read_enable;
        bank_req.write_enable = req.write_enable;
        bank_req.addr         = req.addr;
        bank_req.data         = req.data;
        bank_req.id           = req.id[`MEM_BANK_ID_WIDTH-1:0];
        bank_req.last         = req.last;
    end

    // only the targeted slice can take the request
    assign req_in.ready = slice_ready[bank_sel];

    generate
        for (genvar k = 0; k < `MEM_BANKS; k++) begin : g_bank
            assign slice_in[k].valid   = req_in.valid && (bank_sel == bank_idx_t'(k));
            assign slice_in[k].payload = bank_req;
            assign slice_ready[k]      = slice_in[k].ready;

            stream_reg_slice #(
                .T(mem_bank_req_t)
            ) slice_i (
                .clk   (clk),
                .rst_n (rst_n),
                .in    (slice_in[k]),
                .out   (bank_out[k])
            );
        end
    endgenerate

endmodule

//--- mem_split/mem_resp_merge.sv
// round-robin merge of bank responses into one stream
// bank number put back into the upper id bits
// output registered through one slice

`include "mem_cfg.svh"

module mem_resp_merge
    import mem_pkg::*;
(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  bank_in [`MEM_BANKS],
    stream_intf.out resp_out
);

    logic [`MEM_BANKS-1:0] bank_valid;
    mem_bank_resp_t        bank_resp [`MEM_BANKS];
    bank_idx_t             rr_ptr;
    bank_idx_t             grant_idx;
    logic                  grant_valid;
    mem_bank_resp_t        grant_resp;

    stream_intf #(.T(mem_resp_t)) merged ();

    generate
        for (genvar k = 0; k < `MEM_BANKS; k++) begin : g_bank
            assign bank_valid[k] = bank_in[k].valid;
            assign bank_resp[k]  = bank_in[k].payload;
            assign bank_in[k].ready = merged.ready && grant_valid &&
                                      (grant_idx == bank_idx_t'(k));
        end
    endgenerate

    // first valid bank at or after the pointer wins
    always_comb begin
        bank_idx_t cand;

        grant_idx   = rr_ptr;
        grant_valid = 1'b0;
        for (int i = 0; i < `MEM_BANKS; i++) begin
            cand = rr_ptr + bank_idx_t'(i);
            if (!grant_valid && bank_valid[cand]) begin
                grant_idx   = cand;
                grant_valid = 1'b1;
            end
        end
    end

    assign grant_resp = bank_resp[grant_idx];

    assign merged.valid            = grant_valid;
    assign merged.payload.is_write = grant_resp.is_write;
    assign merged.payload.data     = grant_resp.data;
    assign merged.payload.id       = {grant_idx, grant_resp.id};
    assign merged.payload.last     = grant_resp.last;

    // pointer only moves when a response is actually taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (grant_valid && merged.ready) begin
            rr_ptr <= grant_idx + 1'b1;
        end
    end

    stream_reg_slice #(
        .T(mem_resp_t)
    ) out_slice_i (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (merged),
        .out   (resp_out)
    );

endmodule

//--- design/mem_bank.sv
// single memory bank with byte write masks
// one response register, one response per request

`include "mem_cfg.svh"

module mem_bank
    import mem_pkg::*;
(
    input logic     clk,
    input logic     rst_n,

    stream_intf.in  req,
    stream_intf.out resp
);

    localparam int BYTE_WIDTH = `MEM_DATA_WIDTH / `MEM_MASK_WIDTH;
    localparam int DEPTH      = 2 ** `MEM_ADDR_WIDTH;

    logic [`MEM_DATA_WIDTH-1:0] mem [DEPTH];

    mem_bank_req_t  cur_req;
    mem_bank_resp_t resp_q;
    logic           resp_valid_q;
    logic           accept;

    assign cur_req = req.payload;

    // free slot, or the held response leaves this cycle
    assign req.ready = !resp_valid_q || resp.ready;
    assign accept    = req.valid && req.ready;

    assign resp.valid   = resp_valid_q;
    assign resp.payload = resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else if (accept) begin
            resp_valid_q <= 1'b1;
        end else if (resp.ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    // read returns the word from before this cycle's write
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_q.is_write <= !cur_req.read_enable;
            resp_q.data     <= cur_req.read_enable ? mem[cur_req.addr] : '0;
            resp_q.id       <= cur_req.id;
            resp_q.last     <= cur_req.last;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !cur_req.read_enable) begin
            for (int i = 0; i < `MEM_MASK_WIDTH; i++) begin
                if (cur_req.write_enable[i]) begin
                    mem[cur_req.addr][i*BYTE_WIDTH +: BYTE_WIDTH] <=
                        cur_req.data[i*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

endmodule

//--- design/mem_subsys_top.sv
// top level of the banked memory subsystem
// plain request and response ports
// splitter, four banks and response merger

`include "mem_cfg.svh"

module mem_subsys_top
    import mem_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          req_valid,
    input  logic                          req_read_enable,
    input  logic [`MEM_MASK_WIDTH-1:0]    req_write_enable,
    input  logic [`MEM_ADDR_WIDTH-1:0]    req_addr,
    input  logic [`MEM_DATA_WIDTH-1:0]    req_data,
    input  logic [`MEM_ID_WIDTH-1:0]      req_id,
    input  logic                          req_last,
    output logic                          req_ready,

    output logic                          resp_valid,
    output logic                          resp_is_write,
    output logic [`MEM_DATA_WIDTH-1:0]    resp_data,
    output logic [`MEM_ID_WIDTH-1:0]      resp_id,
    output logic                          resp_last,
    input  logic                          resp_ready
);

    stream_intf #(.T(mem_req_t))       req_if ();
    stream_intf #(.T(mem_bank_req_t))  bank_req_if  [`MEM_BANKS] ();
    stream_intf #(.T(mem_bank_resp_t)) bank_resp_if [`MEM_BANKS] ();
    stream_intf #(.T(mem_resp_t))      resp_if ();

    // request ports into the stream
    assign req_if.valid                = req_valid;
    assign req_if.payload.read_enable  = req_read_enable;
    assign req_if.payload.write_enable = req_write_enable;
    assign req_if.payload.addr         = req_addr;
    assign req_if.payload.data         = req_data;
    assign req_if.payload.id           = req_id;
    assign req_if.payload.last         = req_last;
    assign req_ready                   = req_if.ready;

    // response stream out to ports
    assign resp_valid    = resp_if.valid;
    assign resp_is_write = resp_if.payload.is_write;
    assign resp_data     = resp_if.payload.data;
    assign resp_id       = resp_if.payload.id;
    assign resp_last     = resp_if.payload.last;
    assign resp_if.ready = resp_ready;

    mem_split split_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_in   (req_if),
        .bank_out (bank_req_if)
    );

    generate
        for (genvar k = 0; k < `MEM_BANKS; k++) begin : g_bank
            mem_bank bank_i (
                .clk   (clk),
                .rst_n (rst_n),
                .req   (bank_req_if[k]),
                .resp  (bank_resp_if[k])
            );
        end
    endgenerate

    mem_resp_merge merge_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bank_in  (bank_resp_if),
        .resp_out (resp_if)
    );

endmodule

//--- sim/mem_subsys_asserts.sv
// handshake assertions for the memory subsystem top level
// payload stability under back-pressure, idle response side in reset

`include "mem_cfg.svh"

module mem_subsys_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          req_valid,
    input logic                          req_read_enable,
    input logic [`MEM_MASK_WIDTH-1:0]    req_write_enable,
    input logic [`MEM_ADDR_WIDTH-1:0]    req_addr,
    input logic [`MEM_DATA_WIDTH-1:0]    req_data,
    input logic [`MEM_ID_WIDTH-1:0]      req_id,
    input logic                          req_last,
    input logic                          req_ready,
    input logic                          resp_valid,
    input logic                          resp_is_write,
    input logic [`MEM_DATA_WIDTH-1:0]    resp_data,
    input logic [`MEM_ID_WIDTH-1:0]      resp_id,
    input logic                          resp_last,
    input logic                          resp_ready
);

    // high once reset was seen on the previous edge
    logic in_reset_q = 1'b0;

    always @(posedge clk) begin
        in_reset_q <= !rst_n;
    end

    req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable({req_read_enable,
            req_write_enable, req_addr, req_data, req_id, req_last}))
        else $error("request withdrawn or changed while stalled");

    resp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid &&
            $stable({resp_is_write, resp_data, resp_id, resp_last}))
        else $error("response withdrawn or changed while stalled");

    resp_reset_a: assert property (@(posedge clk) !rst_n && in_reset_q |-> !resp_valid)
        else $error("response valid during reset");

endmodule

bind mem_subsys_top mem_subsys_asserts asserts_i (.*);

//--- sim/mem_subsys_tb.sv
// testbench for the banked memory subsystem
// trace-driven requests and resp_ready stalls
// per-bank reference model, response checks and watchdog

`include "mem_cfg.svh"

module mem_subsys_tb
    import mem_pkg::*;
();

    localparam int RESET_CYCLES      = 10;
    localparam int CYCLES_PER_RECORD = 50;
    localparam int DRAIN_CYCLES      = 200;
    localparam int BYTE_WIDTH        = `MEM_DATA_WIDTH / `MEM_MASK_WIDTH;

    // one trace line, stall length kept in data
    typedef struct packed {
        logic [7:0]                 kind;
        logic [`MEM_ID_WIDTH-1:0]   id;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`MEM_DATA_WIDTH-1:0] data;
        logic [`MEM_MASK_WIDTH-1:0] mask;
        logic                       last;
    } trace_rec_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       req_valid;
    logic                       req_read_enable;
    logic [`MEM_MASK_WIDTH-1:0] req_write_enable;
    logic [`MEM_ADDR_WIDTH-1:0] req_addr;
    logic [`MEM_DATA_WIDTH-1:0] req_data;
    logic [`MEM_ID_WIDTH-1:0]   req_id;
    logic                       req_last;
    logic                       req_ready;
    logic                       resp_valid;
    logic                       resp_is_write;
    logic [`MEM_DATA_WIDTH-1:0] resp_data;
    logic [`MEM_ID_WIDTH-1:0]   resp_id;
    logic                       resp_last;
    logic                       resp_ready;

    trace_rec_t                 recs [$];
    logic [`MEM_DATA_WIDTH-1:0] model_mem [`MEM_BANKS][2**`MEM_ADDR_WIDTH];
    mem_resp_t                  exp_q [`MEM_BANKS][$];
    int                         req_count;
    int                         resp_count;
    logic [31:0]                lcg_state;

    // stall requests handed from the driver to the response side
    int   stall_cycles;
    logic stall_random;
    logic stall_toggle;
    logic stall_seen;
    int   stall_left;
    logic stall_rand_mode;

    mem_subsys_top dut_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic read_trace();
        int                         fd;
        int                         n;
        logic [7:0]                 kind;
        string                      skipped;
        logic [`MEM_ID_WIDTH-1:0]   id;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`MEM_DATA_WIDTH-1:0] data;
        logic [`MEM_MASK_WIDTH-1:0] mask;
        logic                       last;
        trace_rec_t                 rec;

        fd = $fopen("sim/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/mem_trace.txt");
            $display("STATUS: FAIL");
            $fatal(1, "missing trace");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                rec      = '0;
                rec.kind = kind;
                if (kind == "#") begin
                    n = $fgets(skipped, fd);
                end else if (kind == "W" || kind == "R") begin
                    n = $fscanf(fd, "%h %h %h %h %h", id, addr, data, mask, last);
                    rec.id   = id;
                    rec.addr = addr;
                    rec.data = data;
                    rec.mask = mask;
                    rec.last = last;
                    recs.push_back(rec);
                end else begin
                    n = $fscanf(fd, "%d", data);
                    rec.data = data;
                    recs.push_back(rec);
                end
            end
            $fclose(fd);
        end
    endtask

    // expected response and memory update, in acceptance order
    task automatic record_accept(input trace_rec_t rec);
        bank_idx_t bank;
        mem_resp_t exp;

        bank         = rec.id[`MEM_ID_WIDTH-1 -: `MEM_BANK_BITS];
        exp.is_write = (rec.kind == "W");
        exp.id       = rec.id;
        exp.last     = rec.last;
        if (rec.kind == "R") begin
            exp.data = model_mem[bank][rec.addr];
        end else begin
            exp.data = '0;
            for (int i = 0; i < `MEM_MASK_WIDTH; i++) begin
                if (rec.mask[i]) begin
                    model_mem[bank][rec.addr][i*BYTE_WIDTH +: BYTE_WIDTH] =
                        rec.data[i*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
        exp_q[bank].push_back(exp);
        req_count++;
    endtask

    // entered just after a falling edge, leaves at a falling edge
    task automatic send_req(input trace_rec_t rec);
        req_valid        = 1'b1;
        req_read_enable  = (rec.kind == "R");
        req_write_enable = (rec.kind == "R") ? '0 : rec.mask;
        req_addr         = rec.addr;
        req_data         = rec.data;
        req_id           = rec.id;
        req_last         = rec.last;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        record_accept(rec);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic check_resp();
        bank_idx_t bank;
        mem_resp_t exp;

        bank = resp_id[`MEM_ID_WIDTH-1 -: `MEM_BANK_BITS];
        if (exp_q[bank].size() == 0) begin
            $display("response with id %0h at time %0t has no matching request",
                     resp_id, $time);
            $display("STATUS: FAIL");
            $fatal(1, "unexpected response");
        end else begin
            exp = exp_q[bank].pop_front();
            check_value("resp_is_write", 64'(resp_is_write), 64'(exp.is_write));
            check_value("resp_data", 64'(resp_data), 64'(exp.data));
            check_value("resp_id", 64'(resp_id), 64'(exp.id));
            check_value("resp_last", 64'(resp_last), 64'(exp.last));
            resp_count++;
        end
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("run hung, not finished after %0d cycles", cycles);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    // resp_ready pattern and response sampling before the rising edge
    always begin
        @(negedge clk);
        if (stall_toggle != stall_seen) begin
            stall_seen      = stall_toggle;
            stall_left      = stall_cycles;
            stall_rand_mode = stall_random;
        end
        if (stall_left > 0) begin
            stall_left--;
            if (stall_rand_mode) begin
                lcg_state  = lcg_next(lcg_state);
                resp_ready = lcg_state[16];
            end else begin
                resp_ready = 1'b0;
            end
        end else begin
            resp_ready = 1'b1;
        end
        #1;
        if (resp_valid && resp_ready) begin
            check_resp();
        end
    end

    initial begin
        int pending;
        int drain;

        rst_n            = 1'b0;
        req_valid        = 1'b0;
        req_read_enable  = 1'b0;
        req_write_enable = '0;
        req_addr         = '0;
        req_data         = '0;
        req_id           = '0;
        req_last         = 1'b0;
        resp_ready       = 1'b0;
        req_count        = 0;
        resp_count       = 0;
        lcg_state        = 32'h36d933f0;
        stall_cycles     = 0;
        stall_random     = 1'b0;
        stall_toggle     = 1'b0;
        stall_seen       = 1'b0;
        stall_left       = 0;
        stall_rand_mode  = 1'b0;

        read_trace();
        fork
            run_watchdog(RESET_CYCLES + CYCLES_PER_RECORD * recs.size());
        join_none

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("resp_valid in reset", 64'(resp_valid), 64'd0);
            check_value("req_ready in reset", 64'(req_ready), 64'd0);
        end
        rst_n <= 1'b1;

        foreach (recs[i]) begin
            if (recs[i].kind == "W" || recs[i].kind == "R") begin
                send_req(recs[i]);
            end else begin
                stall_cycles <= recs[i].data;
                stall_random <= (recs[i].kind == "X");
                stall_toggle <= !stall_toggle;
            end
        end

        // bounded drain, a lost response shows up as a pending entry
        drain = 0;
        while (resp_count != req_count && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        // idle tail so a duplicated response would still show up
        repeat (20) @(negedge clk);

        pending = 0;
        for (int b = 0; b < `MEM_BANKS; b++) begin
            pending += exp_q[b].size();
        end
        if (pending == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("%0d expected responses never arrived", pending);
            $display("STATUS: FAIL");
            $fatal(1, "missing responses");
        end
    end

endmodule

//--- sim/mem_trace.txt
# request: W|R id addr data mask last (hex), reads ignore data and mask
# stall: S n holds resp_ready low n cycles, X n drives it randomly for n cycles
W 01 10 11223344 f 0
R 02 10 00000000 0 1
W 05 20 aabbccdd f 0
W 06 20 00ee00ff 5 0
R 07 20 00000000 0 1
W 13 10 55667788 f 0
W 21 10 99aabbcc f 0
W 32 10 ddeeff00 f 1
R 03 10 00000000 0 0
R 14 10 00000000 0 0
R 25 10 00000000 0 0
R 36 10 00000000 0 1
S 28
W 08 40 cafef00d f 0
W 09 41 0badf00d f 0
W 0a 40 12345678 c 0
R 0b 40 00000000 0 0
R 0c 41 00000000 0 1
X 80
W 2a 30 deadbeef f 0
R 2b 30 00000000 0 0
W 3c 11 a5a5a5a5 f 0
W 3d 11 5a5a5a5a 3 0
R 3e 11 00000000 0 1
R 18 10 00000000 0 1
R 0d 20 00000000 0 1
W 0e 40 ffffffff 1 0
R 0f 40 00000000 0 1

//--- filelist.f
+incdir+common
common/mem_pkg.sv
common/stream_intf.sv
design/stream_reg_slice.sv
mem_split/mem_split.sv
mem_split/mem_resp_merge.sv
design/mem_bank.sv
design/mem_subsys_top.sv
sim/mem_subsys_asserts.sv
sim/mem_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mem_subsys_tb -f filelist.f -o mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
fi
exit $status
